//--- chroma_pkg.sv
// Chroma mode decision shared types, widths and fixed mode costs
package chroma_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int BLK        = 8;
    localparam int PIX_W      = 8;
    localparam int ROW_W      = 64;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);
    localparam int LAMBDA_W   = 16;
    localparam int SSE_W      = 24;
    localparam int SCORE_W    = 34;

    // Fixed per-mode rate cost, scaled by lambda
    localparam int COST_V  = 302;
    localparam int COST_H  = 984;
    localparam int COST_TM = 439;
    localparam int COST_DC = 642;

    // --------------------
    // Types
    // --------------------
    // Emission order of the producer
    typedef enum logic [1:0] {
        MODE_V  = 2'd0,
        MODE_H  = 2'd1,
        MODE_TM = 2'd2,
        MODE_DC = 2'd3
    } pred_mode_t;

    typedef enum logic {
        GEN_IDLE,
        GEN_EMIT
    } gen_state_t;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_ACC,
        SC_SCORE
    } score_state_t;

endpackage

//--- pred_row_if.sv
// Predicted row stream with mode tag and valid/ready handshake
`timescale 1ns/10ps

interface pred_row_if;

    logic                         valid;
    logic                         ready;
    logic [chroma_pkg::ROW_W-1:0] row_data;
    chroma_pkg::pred_mode_t       mode;
    logic [2:0]                   row_idx;
    // Row 7 of the current mode
    logic                         last_row;

    modport source (
        output valid, row_data, mode, row_idx, last_row,
        input  ready
    );

    modport sink (
        input  valid, row_data, mode, row_idx, last_row,
        output ready
    );

endinterface

//--- intra_pred_gen.sv
// Intra prediction producer emitting V, H, TM and DC rows of an 8x8 chroma block
`timescale 1ns/10ps

module intra_pred_gen (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [chroma_pkg::ROW_W-1:0] top_row,
    input  logic [chroma_pkg::ROW_W-1:0] left_col,
    input  logic [chroma_pkg::PIX_W-1:0] top_left,
    input  logic                         top_avail,
    input  logic                         left_avail,
    pred_row_if.source                   out
);

    chroma_pkg::gen_state_t       state;
    chroma_pkg::pred_mode_t       mode_cnt;
    logic [2:0]                   row_cnt;
    logic                         fire;

    logic [chroma_pkg::ROW_W-1:0] top_q;
    logic [chroma_pkg::ROW_W-1:0] left_q;
    logic [chroma_pkg::PIX_W-1:0] top_left_q;
    logic [chroma_pkg::PIX_W-1:0] dc_q;

    logic [chroma_pkg::PIX_W+2:0] top_sum;
    logic [chroma_pkg::PIX_W+2:0] left_sum;
    logic [chroma_pkg::PIX_W+4:0] dc_sum;
    logic [chroma_pkg::PIX_W-1:0] dc_val;

    logic [chroma_pkg::ROW_W-1:0] row_pred;
    logic [chroma_pkg::PIX_W-1:0] left_pix;
    logic signed [chroma_pkg::PIX_W+1:0] tm_val;

    // --------------------
    // DC value from the incoming neighbors
    // --------------------
    always_comb begin
        top_sum  = '0;
        left_sum = '0;
        for (int i = 0; i < chroma_pkg::BLK; i++) begin
            top_sum  = top_sum + top_row[i*chroma_pkg::PIX_W +: chroma_pkg::PIX_W];
            left_sum = left_sum + left_col[i*chroma_pkg::PIX_W +: chroma_pkg::PIX_W];
        end
        dc_sum = '0;
        dc_val = 8'd128;
        if (top_avail && left_avail) begin
            dc_sum = 13'(top_sum) + 13'(left_sum) + 13'd8;
            dc_val = dc_sum[11:4];
        end else if (top_avail) begin
            dc_sum = 13'(top_sum) + 13'd4;
            dc_val = dc_sum[10:3];
        end else if (left_avail) begin
            dc_sum = 13'(left_sum) + 13'd4;
            dc_val = dc_sum[10:3];
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == chroma_pkg::GEN_IDLE) begin
            top_q      <= top_row;
            left_q     <= left_col;
            top_left_q <= top_left;
            dc_q       <= dc_val;
        end
    end

    // --------------------
    // Row for current mode and row counter
    // --------------------
    always_comb begin
        left_pix = left_q[row_cnt*chroma_pkg::PIX_W +: chroma_pkg::PIX_W];
        row_pred = '0;
        tm_val   = '0;
        for (int c = 0; c < chroma_pkg::BLK; c++) begin
            case (mode_cnt)
                chroma_pkg::MODE_V: begin
                    row_pred[c*8 +: 8] = top_q[c*8 +: 8];
                end
                chroma_pkg::MODE_H: begin
                    row_pred[c*8 +: 8] = left_pix;
                end
                chroma_pkg::MODE_TM: begin
                    tm_val = signed'({2'b00, left_pix}) + signed'({2'b00, top_q[c*8 +: 8]})
                           - signed'({2'b00, top_left_q});
                    // Clip to pixel range
                    if (tm_val < 0)
                        row_pred[c*8 +: 8] = 8'd0;
                    else if (tm_val > 10'sd255)
                        row_pred[c*8 +: 8] = 8'd255;
                    else
                        row_pred[c*8 +: 8] = tm_val[7:0];
                end
                default: begin
                    row_pred[c*8 +: 8] = dc_q;
                end
            endcase
        end
    end

    assign fire         = out.valid && out.ready;
    assign out.valid    = (state == chroma_pkg::GEN_EMIT);
    assign out.row_data = row_pred;
    assign out.mode     = mode_cnt;
    assign out.row_idx  = row_cnt;
    assign out.last_row = (row_cnt == 3'(chroma_pkg::BLK - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= chroma_pkg::GEN_IDLE;
            mode_cnt <= chroma_pkg::MODE_V;
            row_cnt  <= '0;
        end else begin
            case (state)
                chroma_pkg::GEN_IDLE: begin
                    if (start) begin
                        state    <= chroma_pkg::GEN_EMIT;
                        mode_cnt <= chroma_pkg::MODE_V;
                        row_cnt  <= '0;
                    end
                end
                default: begin
                    if (fire) begin
                        row_cnt <= row_cnt + 3'd1;
                        if (out.last_row) begin
                            if (mode_cnt == chroma_pkg::MODE_DC)
                                state <= chroma_pkg::GEN_IDLE;
                            else
                                mode_cnt <= chroma_pkg::pred_mode_t'(mode_cnt + 2'd1);
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- pred_row_fifo.sv
// Four-entry row buffer between the prediction producer and the scorer
`timescale 1ns/10ps

module pred_row_fifo (
    input  logic       clk,
    input  logic       rst_n,
    pred_row_if.sink   in,
    pred_row_if.source out
);

    logic [chroma_pkg::ROW_W-1:0]   data_mem [chroma_pkg::FIFO_DEPTH];
    chroma_pkg::pred_mode_t         mode_mem [chroma_pkg::FIFO_DEPTH];
    logic [2:0]                     idx_mem  [chroma_pkg::FIFO_DEPTH];
    logic                           last_mem [chroma_pkg::FIFO_DEPTH];

    logic [chroma_pkg::FIFO_AW-1:0] wr_ptr;
    logic [chroma_pkg::FIFO_AW-1:0] rd_ptr;
    logic [chroma_pkg::FIFO_CW-1:0] count;
    logic                           wr_en;
    logic                           rd_en;

    assign wr_en    = in.valid && in.ready;
    assign rd_en    = out.valid && out.ready;
    assign in.ready = (count != chroma_pkg::FIFO_CW'(chroma_pkg::FIFO_DEPTH));

    // Head entry
    assign out.valid    = (count != '0);
    assign out.row_data = data_mem[rd_ptr];
    assign out.mode     = mode_mem[rd_ptr];
    assign out.row_idx  = idx_mem[rd_ptr];
    assign out.last_row = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= in.row_data;
            mode_mem[wr_ptr] <= in.mode;
            idx_mem[wr_ptr]  <= in.row_idx;
            last_mem[wr_ptr] <= in.last_row;
        end
    end

    // --------------------
    // Pointers and fill level
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- mode_scorer.sv
// Per-mode SSE accumulation and rate-weighted best mode selection
`timescale 1ns/10ps

module mode_scorer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [chroma_pkg::LAMBDA_W-1:0]       lambda,
    input  logic [chroma_pkg::BLK*chroma_pkg::ROW_W-1:0] src_blk,
    pred_row_if.sink                              in,
    output chroma_pkg::pred_mode_t                best_mode,
    output logic [chroma_pkg::SCORE_W-1:0]        best_score,
    output logic                                  done
);

    chroma_pkg::score_state_t              state;
    logic [chroma_pkg::BLK*chroma_pkg::ROW_W-1:0] src_q;
    logic [chroma_pkg::LAMBDA_W-1:0]       lambda_q;
    logic                                  fire;

    logic [chroma_pkg::ROW_W-1:0]          src_row;
    logic signed [chroma_pkg::PIX_W:0]     diff;
    logic [2*chroma_pkg::PIX_W-1:0]        sq;
    logic [chroma_pkg::SSE_W-1:0]          row_sse;
    logic [chroma_pkg::SSE_W-1:0]          sse_acc;

    chroma_pkg::pred_mode_t                cur_mode;
    chroma_pkg::pred_mode_t                run_mode;
    chroma_pkg::pred_mode_t                win_mode;
    logic [chroma_pkg::SCORE_W-1:0]        cost_sel;
    logic [chroma_pkg::SCORE_W-1:0]        mode_score;
    logic [chroma_pkg::SCORE_W-1:0]        run_score;
    logic [chroma_pkg::SCORE_W-1:0]        win_score;
    logic                                  first_mode;

    assign fire     = in.valid && in.ready;
    assign in.ready = (state == chroma_pkg::SC_ACC);

    // Squared error of the incoming row
    always_comb begin
        src_row = src_q[in.row_idx*chroma_pkg::ROW_W +: chroma_pkg::ROW_W];
        row_sse = '0;
        diff    = '0;
        sq      = '0;
        for (int c = 0; c < chroma_pkg::BLK; c++) begin
            diff    = signed'({1'b0, in.row_data[c*8 +: 8]}) - signed'({1'b0, src_row[c*8 +: 8]});
            sq      = diff * diff;
            row_sse = row_sse + chroma_pkg::SSE_W'(sq);
        end
    end

    // --------------------
    // Score and running comparison
    // --------------------
    always_comb begin
        case (cur_mode)
            chroma_pkg::MODE_V:  cost_sel = chroma_pkg::SCORE_W'(chroma_pkg::COST_V);
            chroma_pkg::MODE_H:  cost_sel = chroma_pkg::SCORE_W'(chroma_pkg::COST_H);
            chroma_pkg::MODE_TM: cost_sel = chroma_pkg::SCORE_W'(chroma_pkg::COST_TM);
            default:             cost_sel = chroma_pkg::SCORE_W'(chroma_pkg::COST_DC);
        endcase
        mode_score = cost_sel * chroma_pkg::SCORE_W'(lambda_q)
                   + (chroma_pkg::SCORE_W'(sse_acc) << 8);
        // Strictly lower wins, so earlier modes keep ties
        if (first_mode || mode_score < run_score) begin
            win_mode  = cur_mode;
            win_score = mode_score;
        end else begin
            win_mode  = run_mode;
            win_score = run_score;
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == chroma_pkg::SC_IDLE) begin
            src_q    <= src_blk;
            lambda_q <= lambda;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= chroma_pkg::SC_IDLE;
            sse_acc    <= '0;
            cur_mode   <= chroma_pkg::MODE_V;
            run_mode   <= chroma_pkg::MODE_V;
            run_score  <= '0;
            first_mode <= 1'b0;
            best_mode  <= chroma_pkg::MODE_V;
            best_score <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                chroma_pkg::SC_IDLE: begin
                    if (start) begin
                        state      <= chroma_pkg::SC_ACC;
                        sse_acc    <= '0;
                        first_mode <= 1'b1;
                    end
                end
                chroma_pkg::SC_ACC: begin
                    if (fire) begin
                        sse_acc <= sse_acc + row_sse;
                        if (in.last_row) begin
                            cur_mode <= in.mode;
                            state    <= chroma_pkg::SC_SCORE;
                        end
                    end
                end
                chroma_pkg::SC_SCORE: begin
                    run_mode   <= win_mode;
                    run_score  <= win_score;
                    first_mode <= 1'b0;
                    sse_acc    <= '0;
                    if (cur_mode == chroma_pkg::MODE_DC) begin
                        best_mode  <= win_mode;
                        best_score <= win_score;
                        done       <= 1'b1;
                        state      <= chroma_pkg::SC_IDLE;
                    end else begin
                        state <= chroma_pkg::SC_ACC;
                    end
                end
                default: state <= chroma_pkg::SC_IDLE;
            endcase
        end
    end

endmodule

//--- chroma_mode_decide.sv
// Chroma intra mode decision top level with start gating and busy tracking
`timescale 1ns/10ps

module chroma_mode_decide (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [chroma_pkg::LAMBDA_W-1:0]       lambda,
    input  logic [chroma_pkg::BLK*chroma_pkg::ROW_W-1:0] src_blk,
    input  logic [chroma_pkg::ROW_W-1:0]          top_row,
    input  logic [chroma_pkg::ROW_W-1:0]          left_col,
    input  logic [chroma_pkg::PIX_W-1:0]          top_left,
    input  logic                                  top_avail,
    input  logic                                  left_avail,
    output chroma_pkg::pred_mode_t                best_mode,
    output logic [chroma_pkg::SCORE_W-1:0]        best_score,
    output logic                                  busy,
    output logic                                  done
);

    logic busy_q;
    logic start_acc;

    pred_row_if gen_if ();
    pred_row_if fifo_if ();

    // Starts while a block is in flight are dropped
    assign start_acc = start && !busy;
    // Busy drops in the same cycle that done rises
    assign busy      = busy_q && !done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            busy_q <= 1'b0;
        else if (start_acc)
            busy_q <= 1'b1;
        else if (done)
            busy_q <= 1'b0;
    end

    intra_pred_gen i_intra_pred_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start_acc),
        .top_row    (top_row),
        .left_col   (left_col),
        .top_left   (top_left),
        .top_avail  (top_avail),
        .left_avail (left_avail),
        .out        (gen_if.source)
    );

    pred_row_fifo i_pred_row_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (gen_if.sink),
        .out   (fifo_if.source)
    );

    mode_scorer i_mode_scorer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start_acc),
        .lambda     (lambda),
        .src_blk    (src_blk),
        .in         (fifo_if.sink),
        .best_mode  (best_mode),
        .best_score (best_score),
        .done       (done)
    );

endmodule

//--- chroma_mode_decide_asserts.sv
// Protocol checks on busy, done and the result outputs of the mode decision top level
`timescale 1ns/10ps

module chroma_mode_decide_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           start,
    input logic                           busy,
    input logic                           done,
    input chroma_pkg::pred_mode_t         best_mode,
    input logic [chroma_pkg::SCORE_W-1:0] best_score
);

    int fail_cnt = 0;

    // --------------------
    // Handshake
    // --------------------
    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done)
        else begin
            $error("busy or done high right after reset");
            fail_cnt++;
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_cnt++;
        end

    done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
        else begin
            $error("done without a block in progress");
            fail_cnt++;
        end

    // Accepted start raises busy on the next edge
    start_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start && !busy |=> busy)
        else begin
            $error("busy did not rise after an accepted start");
            fail_cnt++;
        end

    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        !done |-> $stable(best_mode) && $stable(best_score))
        else begin
            $error("best_mode or best_score changed without done");
            fail_cnt++;
        end

endmodule

bind chroma_mode_decide chroma_mode_decide_asserts i_chroma_mode_decide_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .best_mode  (best_mode),
    .best_score (best_score)
);

//--- tb_chroma_mode_decide.sv
// Testbench for the chroma intra mode decision block with reference model and result checks
`timescale 1ns/10ps

module tb_chroma_mode_decide;

    localparam int     CLK_NS      = 10;
    localparam int     RST_CYCLES  = 16;
    localparam int     NUM_BLOCKS  = 40;
    localparam int     BLOCK_LIMIT = 60;
    localparam longint WATCHDOG_NS = NUM_BLOCKS * BLOCK_LIMIT * CLK_NS + RST_CYCLES * CLK_NS;

    logic                                         clk;
    logic                                         rst_n;
    logic                                         start;
    logic [chroma_pkg::LAMBDA_W-1:0]              lambda;
    logic [chroma_pkg::BLK*chroma_pkg::ROW_W-1:0] src_blk;
    logic [chroma_pkg::ROW_W-1:0]                 top_row;
    logic [chroma_pkg::ROW_W-1:0]                 left_col;
    logic [chroma_pkg::PIX_W-1:0]                 top_left;
    logic                                         top_avail;
    logic                                         left_avail;
    chroma_pkg::pred_mode_t                       best_mode;
    logic [chroma_pkg::SCORE_W-1:0]               best_score;
    logic                                         busy;
    logic                                         done;

    // Block under test as the model sees it
    logic [chroma_pkg::BLK*chroma_pkg::ROW_W-1:0] m_src;
    logic [chroma_pkg::ROW_W-1:0]                 m_top;
    logic [chroma_pkg::ROW_W-1:0]                 m_left;
    logic [chroma_pkg::PIX_W-1:0]                 m_tl;
    logic                                         m_ta;
    logic                                         m_la;
    logic [chroma_pkg::LAMBDA_W-1:0]              m_lam;
    int                                           exp_mode;
    longint                                       exp_score;
    int                                           result_errs;
    int                                           timeout_errs;
    int                                           protocol_errs;

    chroma_mode_decide i_chroma_mode_decide (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .lambda     (lambda),
        .src_blk    (src_blk),
        .top_row    (top_row),
        .left_col   (left_col),
        .top_left   (top_left),
        .top_avail  (top_avail),
        .left_avail (left_avail),
        .best_mode  (best_mode),
        .best_score (best_score),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic int pix(logic [63:0] row, int i);
        return int'(row[i*8 +: 8]);
    endfunction

    function automatic int dc_value();
        int st;
        int sl;
        st = 0;
        sl = 0;
        for (int i = 0; i < chroma_pkg::BLK; i++) begin
            st += pix(m_top, i);
            sl += pix(m_left, i);
        end
        if (m_ta && m_la)
            return (st + sl + 8) >> 4;
        if (m_ta)
            return (st + 4) >> 3;
        if (m_la)
            return (sl + 4) >> 3;
        return 128;
    endfunction

    function automatic int pred_pixel(int m, int r, int c, int dc);
        int tm;
        case (m)
            0: return pix(m_top, c);
            1: return pix(m_left, r);
            2: begin
                tm = pix(m_left, r) + pix(m_top, c) - int'(m_tl);
                return (tm < 0) ? 0 : ((tm > 255) ? 255 : tm);
            end
            default: return dc;
        endcase
    endfunction

    task automatic predict_best();
        int     cost [4] = '{chroma_pkg::COST_V, chroma_pkg::COST_H,
                             chroma_pkg::COST_TM, chroma_pkg::COST_DC};
        int     dc;
        int     d;
        longint sse;
        longint score;
        dc = dc_value();
        for (int m = 0; m < 4; m++) begin
            sse = 0;
            for (int r = 0; r < chroma_pkg::BLK; r++) begin
                for (int c = 0; c < chroma_pkg::BLK; c++) begin
                    d = pred_pixel(m, r, c, dc) - pix(m_src[r*64 +: 64], c);
                    sse += d * d;
                end
            end
            score = longint'(cost[m]) * longint'(m_lam) + (sse << 8);
            // First mode keeps a tie
            if (m == 0 || score < exp_score) begin
                exp_mode  = m;
                exp_score = score;
            end
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic randomize_block();
        for (int w = 0; w < 16; w++)
            m_src[w*32 +: 32] = $urandom;
        m_top  = {$urandom, $urandom};
        m_left = {$urandom, $urandom};
        m_tl   = 8'($urandom);
        m_ta   = 1'($urandom);
        m_la   = 1'($urandom);
        m_lam  = 16'($urandom);
    endtask

    task automatic src_from_mode(int m);
        int dc;
        dc = dc_value();
        for (int r = 0; r < chroma_pkg::BLK; r++)
            for (int c = 0; c < chroma_pkg::BLK; c++)
                m_src[(r*8 + c)*8 +: 8] = 8'(pred_pixel(m, r, c, dc));
    endtask

    task automatic run_block(bit stray_start);
        int cycles;
        predict_best();
        @(posedge clk);
        start      <= 1'b1;
        lambda     <= m_lam;
        src_blk    <= m_src;
        top_row    <= m_top;
        left_col   <= m_left;
        top_left   <= m_tl;
        top_avail  <= m_ta;
        left_avail <= m_la;
        @(posedge clk);
        start <= 1'b0;
        if (stray_start) begin
            // Second start with other inputs while the block runs
            repeat (3) @(posedge clk);
            start      <= 1'b1;
            lambda     <= 16'($urandom);
            src_blk    <= ~m_src;
            top_row    <= ~m_top;
            left_col   <= ~m_left;
            top_avail  <= ~m_ta;
            left_avail <= ~m_la;
            @(posedge clk);
            start <= 1'b0;
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < BLOCK_LIMIT);
        if (!done) begin
            $display("Block did not finish within %0d cycles at %0t", BLOCK_LIMIT, $time);
            timeout_errs++;
        end else begin
            assert (int'(best_mode) == exp_mode) else begin
                $display("error %0t best_mode expected %0d actual %0d",
                         $time, exp_mode, best_mode);
                result_errs++;
            end
            assert (longint'(best_score) == exp_score) else begin
                $display("error %0t best_score expected %0d actual %0d",
                         $time, exp_score, best_score);
                result_errs++;
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        void'($urandom(32'h608c_90d9));
        rst_n        = 1'b0;
        start        = 1'b0;
        lambda       = '0;
        src_blk      = '0;
        top_row      = '0;
        left_col     = '0;
        top_left     = '0;
        top_avail    = 1'b0;
        left_avail   = 1'b0;
        result_errs  = 0;
        timeout_errs = 0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Source equal to one mode's prediction
        for (int m = 0; m < 4; m++) begin
            randomize_block();
            m_ta  = 1'b1;
            m_la  = 1'b1;
            m_lam = '0;
            src_from_mode(m);
            run_block(1'b0);
        end

        // Flat neighbors, all SSEs zero so the rate term decides
        randomize_block();
        m_top  = {8{m_tl}};
        m_left = {8{m_tl}};
        m_ta   = 1'b1;
        m_la   = 1'b1;
        m_lam  = 16'($urandom_range(1, 65535));
        src_from_mode(3);
        run_block(1'b0);

        for (int a = 0; a < 4; a++) begin
            randomize_block();
            m_ta  = a[0];
            m_la  = a[1];
            m_lam = 16'($urandom_range(0, 15));
            src_from_mode(3);
            run_block(1'b0);
        end

        for (int n = 0; n < 30; n++) begin
            randomize_block();
            run_block(n % 3 == 0);
        end

        repeat (2) @(posedge clk);
        protocol_errs = i_chroma_mode_decide.i_chroma_mode_decide_asserts.fail_cnt;
        $display("Errors: %0d result, %0d timeout, %0d protocol",
                 result_errs, timeout_errs, protocol_errs);
        if (result_errs == 0 && timeout_errs == 0 && protocol_errs == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- build.f
chroma_pkg.sv
pred_row_if.sv
intra_pred_gen.sv
pred_row_fifo.sv
mode_scorer.sv
chroma_mode_decide.sv
chroma_mode_decide_asserts.sv
tb_chroma_mode_decide.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the chroma mode decision testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_chroma_mode_decide -f build.f \
    && ./obj_dir/Vtb_chroma_mode_decide +verilator+error+limit+1000 ; } > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
    && echo "Run passed" \
    || { echo "Run failed, see sim.log"; exit 1; }
